// File: Makefile
TOP = tb_board_supervisor

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --top-module $(TOP) -f files.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: board_supervisor.sv
`timescale 1ns/1ps

`include "supervisor_consts.svh"

module board_supervisor #(
    parameter int unsigned hold_cycles   = `SUP_HOLD_CYCLES,
    parameter int          glow_slow_bit = `SUP_GLOW_SLOW_BIT,
    parameter int          glow_fast_bit = `SUP_GLOW_FAST_BIT,
    parameter int          blink_bit     = `SUP_BLINK_BIT
) (
    input  logic                          control_clock,
    input  logic                          reset_dc,
    input  logic                          pll54_locked,
    input  logic                          pll_hdmi_locked,
    input  logic                          resync,
    input  logic                          force_generate,
    input  logic                          console_reset_req,
    input  logic                          option_reset_req,
    input  logic                          hdmi_tx_ready,
    input  supervisor_pkg::led_mode_t      led_mode,
    input  logic                          req_valid,
    input  logic                          rsp_ready,
    input  supervisor_pkg::counter_index_t req_index,
    output logic                          req_ready,
    output logic                          rsp_valid,
    output supervisor_pkg::event_count_t  rsp_data,
    output logic                          console_reset_held,
    output logic                          option_reset_held,
    output logic                          status_led
);

    logic pll54_lockloss;
    logic pll_hdmi_lockloss;
    logic resync_event;
    logic pll_hdmi_locked_sync;
    logic resync_sync;
    logic force_generate_sync;

    input_sync i_input_sync (
        .control_clock(control_clock),
        .reset_dc(reset_dc),
        .pll54_locked(pll54_locked),
        .pll_hdmi_locked(pll_hdmi_locked),
        .resync(resync),
        .force_generate(force_generate),
        .pll54_lockloss(pll54_lockloss),
        .pll_hdmi_lockloss(pll_hdmi_lockloss),
        .resync_event(resync_event),
        .pll_hdmi_locked_sync(pll_hdmi_locked_sync),
        .resync_sync(resync_sync),
        .force_generate_sync(force_generate_sync)
    );

    event_counters i_event_counters (
        .control_clock(control_clock),
        .reset_dc(reset_dc),
        .pll54_lockloss(pll54_lockloss),
        .pll_hdmi_lockloss(pll_hdmi_lockloss),
        .resync_event(resync_event),
        .req_valid(req_valid),
        .req_index(req_index),
        .rsp_ready(rsp_ready),
        .req_ready(req_ready),
        .rsp_valid(rsp_valid),
        .rsp_data(rsp_data)
    );

    ////////////////////
    // reset hold generators
    reset_hold #(
        .hold_cycles(hold_cycles)
    ) i_console_hold (
        .control_clock(control_clock),
        .reset_dc(reset_dc),
        .request(console_reset_req),
        .held(console_reset_held)
    );

    reset_hold #(
        .hold_cycles(hold_cycles)
    ) i_option_hold (
        .control_clock(control_clock),
        .reset_dc(reset_dc),
        .request(option_reset_req),
        .held(option_reset_held)
    );

    status_led #(
        .glow_slow_bit(glow_slow_bit),
        .glow_fast_bit(glow_fast_bit),
        .blink_bit(blink_bit)
    ) i_status_led (
        .control_clock(control_clock),
        .reset_dc(reset_dc),
        .led_mode(led_mode),
        .pll_hdmi_locked_sync(pll_hdmi_locked_sync),
        .resync_sync(resync_sync),
        .force_generate_sync(force_generate_sync),
        .hdmi_tx_ready(hdmi_tx_ready),
        .console_reset_held(console_reset_held),
        .option_reset_held(option_reset_held),
        .status_led(status_led)
    );

endmodule

// File: event_counters.sv
`timescale 1ns/1ps

module event_counters (
    input  logic                          control_clock,
    input  logic                          reset_dc,
    input  logic                          pll54_lockloss,
    input  logic                          pll_hdmi_lockloss,
    input  logic                          resync_event,
    input  logic                          req_valid,
    input  supervisor_pkg::counter_index_t req_index,
    input  logic                          rsp_ready,
    output logic                          req_ready,
    output logic                          rsp_valid,
    output supervisor_pkg::event_count_t  rsp_data
);

    import supervisor_pkg::*;

    event_count_t pll54_count;
    event_count_t pll_hdmi_count;
    event_count_t resync_count;
    event_count_t selected;
    logic         transfer;

    ////////////////////
    // event counts
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            pll54_count    <= '0;
            pll_hdmi_count <= '0;
            resync_count   <= '0;
        end else begin
            if (pll54_lockloss) begin
                pll54_count <= pll54_count + 1'b1;
            end
            if (pll_hdmi_lockloss) begin
                pll_hdmi_count <= pll_hdmi_count + 1'b1;
            end
            if (resync_event) begin
                resync_count <= resync_count + 1'b1;
            end
        end
    end

    ////////////////////
    // read port
    // one read in flight, next request waits for the response to drain
    assign req_ready = ~rsp_valid;
    assign transfer  = req_valid & req_ready;

    always_comb begin
        case (req_index)
            2'd0:    selected = pll54_count;
            2'd1:    selected = pll_hdmi_count;
            2'd2:    selected = resync_count;
            default: selected = '0;
        endcase
    end

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            rsp_valid <= 1'b0;
        end else if (transfer) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    // count is captured at transfer time and held under back-pressure
    always_ff @(posedge control_clock) begin
        if (transfer) begin
            rsp_data <= selected;
        end
    end

endmodule

// File: files.f
+incdir+.
supervisor_pkg.sv
input_sync.sv
event_counters.sv
reset_hold.sv
led_glow.sv
status_led.sv
board_supervisor.sv
tb_board_supervisor.sv

// File: input_sync.sv
`timescale 1ns/1ps

module input_sync (
    input  logic control_clock,
    input  logic reset_dc,
    input  logic pll54_locked,
    input  logic pll_hdmi_locked,
    input  logic resync,
    input  logic force_generate,
    output logic pll54_lockloss,
    output logic pll_hdmi_lockloss,
    output logic resync_event,
    output logic pll_hdmi_locked_sync,
    output logic resync_sync,
    output logic force_generate_sync
);

    // bit order: force_generate, resync, hdmi lock, 54 lock
    // locks start high so leaving reset is not a loss
    localparam logic [3:0] sync_init = 4'b0011;

    logic [3:0] async_in;
    logic [3:0] meta;
    logic [3:0] sync;
    logic [2:0] prev;

    assign async_in = {force_generate, resync, pll_hdmi_locked, pll54_locked};

    ////////////////////
    // two-flop synchronizers
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            meta <= sync_init;
            sync <= sync_init;
        end else begin
            meta <= async_in;
            sync <= meta;
        end
    end

    ////////////////////
    // edge detectors, registered pulses
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            prev              <= sync_init[2:0];
            pll54_lockloss    <= 1'b0;
            pll_hdmi_lockloss <= 1'b0;
            resync_event      <= 1'b0;
        end else begin
            prev              <= sync[2:0];
            pll54_lockloss    <= prev[0] & ~sync[0];
            pll_hdmi_lockloss <= prev[1] & ~sync[1];
            resync_event      <= ~prev[2] & sync[2];
        end
    end

    assign pll_hdmi_locked_sync = sync[1];
    assign resync_sync          = sync[2];
    assign force_generate_sync  = sync[3];

endmodule

// File: led_glow.sv
`timescale 1ns/1ps

`include "supervisor_consts.svh"

module led_glow #(
    parameter int top_bit = `SUP_GLOW_SLOW_BIT
) (
    input  logic control_clock,
    input  logic reset_dc,
    output logic glow
);

    logic [top_bit:0] count;
    logic [7:0]       level;
    logic [7:0]       brightness;

    // top bit picks ramp direction, the next 8 bits give the level
    assign level      = count[top_bit-1 -: 8];
    assign brightness = count[top_bit] ? level : ~level;

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            count <= '0;
            glow  <= 1'b0;
        end else begin
            count <= count + 1'b1;
            // pwm against the low byte
            glow  <= brightness > count[7:0];
        end
    end

endmodule

// File: reset_hold.sv
`timescale 1ns/1ps

`include "supervisor_consts.svh"

module reset_hold #(
    parameter int unsigned hold_cycles = `SUP_HOLD_CYCLES
) (
    input  logic control_clock,
    input  logic reset_dc,
    input  logic request,
    output logic held
);

    import supervisor_pkg::*;

    localparam hold_count_t hold_last = hold_count_t'(hold_cycles);

    hold_count_t count;

    // request restarts the timer, release once it reaches hold_last
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            count <= '0;
            held  <= 1'b0;
        end else if (request) begin
            count <= '0;
            held  <= 1'b1;
        end else if (held) begin
            count <= count + 1'b1;
            if (count == hold_last) begin
                held <= 1'b0;
            end
        end
    end

endmodule

// File: status_led.sv
`timescale 1ns/1ps

`include "supervisor_consts.svh"

module status_led #(
    parameter int glow_slow_bit = `SUP_GLOW_SLOW_BIT,
    parameter int glow_fast_bit = `SUP_GLOW_FAST_BIT,
    parameter int blink_bit     = `SUP_BLINK_BIT
) (
    input  logic                     control_clock,
    input  logic                     reset_dc,
    input  supervisor_pkg::led_mode_t led_mode,
    input  logic                     pll_hdmi_locked_sync,
    input  logic                     resync_sync,
    input  logic                     force_generate_sync,
    input  logic                     hdmi_tx_ready,
    input  logic                     console_reset_held,
    input  logic                     option_reset_held,
    output logic                     status_led
);

    import supervisor_pkg::*;

    logic             slow_glow;
    logic             fast_glow;
    logic [blink_bit:0] blink_count;
    led_source_t      source;
    logic             status_level;
    logic             led_next;

    led_glow #(
        .top_bit(glow_slow_bit)
    ) i_slow_glow (
        .control_clock(control_clock),
        .reset_dc(reset_dc),
        .glow(slow_glow)
    );

    led_glow #(
        .top_bit(glow_fast_bit)
    ) i_fast_glow (
        .control_clock(control_clock),
        .reset_dc(reset_dc),
        .glow(fast_glow)
    );

    ////////////////////
    // status mode source, highest priority first
    always_comb begin
        if (!pll_hdmi_locked_sync) begin
            source = src_on;
        end else if (resync_sync) begin
            source = src_fast_glow;
        end else if (force_generate_sync) begin
            source = src_blink;
        end else if (hdmi_tx_ready) begin
            source = src_off;
        end else begin
            source = src_slow_glow;
        end
    end

    always_comb begin
        case (source)
            src_off:       status_level = 1'b0;
            src_slow_glow: status_level = ~slow_glow;
            src_fast_glow: status_level = ~fast_glow;
            src_blink:     status_level = blink_count[blink_bit] ? ~fast_glow : 1'b1;
            default:       status_level = 1'b1;
        endcase
    end

    // console mirrors its hold, any other code mirrors the option hold
    always_comb begin
        case (led_mode)
            led_status:  led_next = status_level;
            led_console: led_next = ~console_reset_held;
            default:     led_next = ~option_reset_held;
        endcase
    end

    ////////////////////
    // blink counter and output register
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            blink_count <= '0;
            status_led  <= 1'b1;
        end else begin
            blink_count <= blink_count + 1'b1;
            status_led  <= led_next;
        end
    end

endmodule

// File: supervisor_cases.txt
# operation arg_a arg_b expected, all decimal
# reset cycles - led | read index - count | hold which mode cycles | lockloss which pulses count
# resync pulses - count | led_level lock tx_ready led | led_toggle window - min_toggles
reset 4 0 1
read 0 0 0
read 1 0 0
read 2 0 0
read 3 0 0
hold 0 2 21
hold 1 1 21
hold 1 3 21
hold 0 0 21
lockloss 0 3 3
lockloss 1 2 2
lockloss 0 1 4
read 1 0 2
resync 5 0 5
resync 2 0 7
read 2 0 7
read 3 0 0
led_level 0 0 1
led_level 1 1 0
led_level 0 1 1
read 1 0 4
led_toggle 2048 0 1
read 2 0 8
read 0 0 4

// File: supervisor_consts.svh
`ifndef SUPERVISOR_CONSTS_SVH
`define SUPERVISOR_CONSTS_SVH

// console and option reset hold, in control clock cycles
`define SUP_HOLD_CYCLES 32000000

// top counter bits of the two glow generators
`define SUP_GLOW_SLOW_BIT 26
`define SUP_GLOW_FAST_BIT 22

// free counter bit that gates the blink
`define SUP_BLINK_BIT 24

`define SUP_COUNT_W 32

`endif

// File: supervisor_pkg.sv
`include "supervisor_consts.svh"

package supervisor_pkg;

    // one event count, as read on the register port
    typedef logic [`SUP_COUNT_W-1:0] event_count_t;

    // 0 clock-54 losses, 1 hdmi clock losses, 2 resyncs, 3 reads zero
    typedef logic [1:0] counter_index_t;

    typedef logic [31:0] hold_count_t;

    // codes 1 and 3 both mirror the option reset
    typedef enum logic [1:0] {
        led_status  = 2'd0,
        led_option  = 2'd1,
        led_console = 2'd2
    } led_mode_t;

    typedef enum logic [2:0] {
        src_off,
        src_on,
        src_slow_glow,
        src_fast_glow,
        src_blink
    } led_source_t;

endpackage

// File: tb_board_supervisor.sv
`timescale 1ns/1ps

module tb_board_supervisor;

    import supervisor_pkg::*;

    logic           control_clock;
    logic           reset_dc;
    logic           pll54_locked;
    logic           pll_hdmi_locked;
    logic           resync;
    logic           force_generate;
    logic           console_reset_req;
    logic           option_reset_req;
    logic           hdmi_tx_ready;
    led_mode_t      led_mode;
    logic           req_valid;
    logic           rsp_ready;
    counter_index_t req_index;
    logic           req_ready;
    logic           rsp_valid;
    event_count_t   rsp_data;
    logic           console_reset_held;
    logic           option_reset_held;
    logic           status_led;

    int case_count;

    board_supervisor #(
        .hold_cycles(20),
        .glow_slow_bit(11),
        .glow_fast_bit(9),
        .blink_bit(10)
    ) i_board_supervisor (
        .control_clock(control_clock),
        .reset_dc(reset_dc),
        .pll54_locked(pll54_locked),
        .pll_hdmi_locked(pll_hdmi_locked),
        .resync(resync),
        .force_generate(force_generate),
        .console_reset_req(console_reset_req),
        .option_reset_req(option_reset_req),
        .hdmi_tx_ready(hdmi_tx_ready),
        .led_mode(led_mode),
        .req_valid(req_valid),
        .rsp_ready(rsp_ready),
        .req_index(req_index),
        .req_ready(req_ready),
        .rsp_valid(rsp_valid),
        .rsp_data(rsp_data),
        .console_reset_held(console_reset_held),
        .option_reset_held(option_reset_held),
        .status_led(status_led)
    );

    initial begin
        control_clock = 1'b0;
        forever #5 control_clock = ~control_clock;
    end

    ////////////////////
    // checks and failure paths
    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0d ns: %s, got %0d, expected %0d",
                     $time, what, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic timed_out(input string what);
        $display("timeout at %0d ns while waiting for %s", $time, what);
        $display("TESTBENCH FAILED");
        $fatal(1, "wait timed out");
    endtask

    task automatic apply_reset(input int cycles, input logic [31:0] expected_led);
        reset_dc = 1'b1;
        repeat (cycles) @(negedge control_clock);
        reset_dc = 1'b0;
        check_value(32'(console_reset_held), 32'd0, "console hold after reset");
        check_value(32'(option_reset_held), 32'd0, "option hold after reset");
        check_value(32'(rsp_valid), 32'd0, "rsp_valid after reset");
        check_value(32'(req_ready), 32'd1, "req_ready after reset");
        check_value(32'(status_led), expected_led, "status led after reset");
    endtask

    ////////////////////
    // register read with random response stalls
    task automatic read_counter(input int index, input logic [31:0] expected);
        int          stall;
        int          waited;
        logic [31:0] held_data;
        check_value(32'(req_ready), 32'd1, "req_ready before read");
        req_index = counter_index_t'(index[1:0]);
        req_valid = 1'b1;
        rsp_ready = 1'b0;
        waited = 0;
        @(negedge control_clock);
        while (!rsp_valid) begin
            waited++;
            if (waited > 16) begin
                timed_out("read response");
            end
            @(negedge control_clock);
        end
        req_valid = 1'b0;
        held_data = rsp_data;
        stall = int'($urandom % 4);
        repeat (stall) begin
            check_value(32'(req_ready), 32'd0, "req_ready while response pending");
            @(negedge control_clock);
            check_value(32'(rsp_valid), 32'd1, "rsp_valid during stall");
            check_value(rsp_data, held_data, "rsp_data during stall");
        end
        check_value(32'(req_ready), 32'd0, "req_ready while response pending");
        rsp_ready = 1'b1;
        @(negedge control_clock);
        rsp_ready = 1'b0;
        check_value(32'(rsp_valid), 32'd0, "rsp_valid after accept");
        check_value(32'(req_ready), 32'd1, "req_ready after accept");
        check_value(held_data, expected, $sformatf("count at index %0d", index));
    endtask

    ////////////////////
    // reset hold, with the led mirror check when the mode matches
    task automatic run_hold(input int which, input int mode, input int expected);
        int   high_cycles;
        logic mirror;
        logic held_now;
        logic prev_held;
        logic want;
        mirror = (which == 0) ? (mode == 2) : (mode == 1 || mode == 3);
        led_mode = led_mode_t'(mode[1:0]);
        repeat (3) @(negedge control_clock);
        if (which == 0) begin
            console_reset_req = 1'b1;
        end else begin
            option_reset_req = 1'b1;
        end
        @(negedge control_clock);
        console_reset_req = 1'b0;
        option_reset_req = 1'b0;
        held_now = (which == 0) ? console_reset_held : option_reset_held;
        check_value(32'(held_now), 32'd1, "hold rises on the edge after the request");
        prev_held = 1'b0;
        high_cycles = 0;
        while (held_now) begin
            want = ~prev_held;
            check_value(32'((which == 0) ? option_reset_held : console_reset_held), 32'd0,
                        "other hold stays low");
            if (mirror) begin
                check_value(32'(status_led), 32'(want), "led mirrors hold");
            end
            high_cycles++;
            if (high_cycles > 1000) begin
                timed_out("reset hold release");
            end
            prev_held = held_now;
            @(negedge control_clock);
            held_now = (which == 0) ? console_reset_held : option_reset_held;
        end
        check_value(32'(high_cycles), 32'(expected), "hold length in cycles");
        if (mirror) begin
            want = ~prev_held;
            check_value(32'(status_led), 32'(want), "led follows hold release");
            @(negedge control_clock);
            check_value(32'(status_led), 32'd1, "led back high after hold");
        end
    endtask

    task automatic drive_lock(input int which, input logic level);
        if (which == 0) begin
            pll54_locked = level;
        end else begin
            pll_hdmi_locked = level;
        end
    endtask

    task automatic pulse_lock(input int which, input int pulses, input logic [31:0] expected);
        repeat (pulses) begin
            drive_lock(which, 1'b0);
            repeat (4) @(negedge control_clock);
            drive_lock(which, 1'b1);
            repeat (4) @(negedge control_clock);
        end
        // sync, edge detect and count
        repeat (5) @(negedge control_clock);
        read_counter(which, expected);
    endtask

    task automatic pulse_resync(input int pulses, input logic [31:0] expected);
        repeat (pulses) begin
            resync = 1'b1;
            repeat (4) @(negedge control_clock);
            resync = 1'b0;
            repeat (4) @(negedge control_clock);
        end
        repeat (5) @(negedge control_clock);
        read_counter(2, expected);
    endtask

    ////////////////////
    // status mode led
    task automatic check_led_level(input int lock, input int tx_ready,
                                   input logic [31:0] expected);
        led_mode = led_status;
        resync = 1'b0;
        force_generate = 1'b0;
        pll_hdmi_locked = (lock != 0);
        hdmi_tx_ready = (tx_ready != 0);
        repeat (6) @(negedge control_clock);
        repeat (8) begin
            check_value(32'(status_led), expected, "status mode led level");
            @(negedge control_clock);
        end
    endtask

    task automatic check_led_toggle(input int window, input int min_toggles);
        int   toggles;
        logic last;
        logic enough;
        led_mode = led_status;
        // tx ready alone would hold the led low, so toggling needs resync priority
        hdmi_tx_ready = 1'b1;
        pll_hdmi_locked = 1'b1;
        resync = 1'b1;
        repeat (6) @(negedge control_clock);
        toggles = 0;
        last = status_led;
        for (int i = 0; i < window; i++) begin
            @(negedge control_clock);
            if (status_led != last) begin
                toggles++;
            end
            last = status_led;
        end
        enough = (toggles >= min_toggles);
        check_value(32'(enough), 32'd1, "led toggles under resync");
        resync = 1'b0;
        repeat (6) @(negedge control_clock);
    endtask

    task automatic run_case(input string op, input int arg_a, input int arg_b,
                            input int expected);
        if (op == "reset") begin
            apply_reset(arg_a, expected);
        end else if (op == "read") begin
            read_counter(arg_a, expected);
        end else if (op == "hold") begin
            run_hold(arg_a, arg_b, expected);
        end else if (op == "lockloss") begin
            pulse_lock(arg_a, arg_b, expected);
        end else if (op == "resync") begin
            pulse_resync(arg_a, expected);
        end else if (op == "led_level") begin
            check_led_level(arg_a, arg_b, expected);
        end else if (op == "led_toggle") begin
            check_led_toggle(arg_a, expected);
        end else begin
            $display("unknown operation %s in the case file", op);
            $display("TESTBENCH FAILED");
            $fatal(1, "bad case file");
        end
    endtask

    ////////////////////
    // main sequence
    initial begin
        int    fd;
        int    fields;
        int    arg_a;
        int    arg_b;
        int    expected;
        string line;
        string op;
        void'($urandom(32'hbe477120));
        reset_dc = 1'b1;
        pll54_locked = 1'b1;
        pll_hdmi_locked = 1'b1;
        resync = 1'b0;
        force_generate = 1'b0;
        console_reset_req = 1'b0;
        option_reset_req = 1'b0;
        hdmi_tx_ready = 1'b0;
        led_mode = led_status;
        req_valid = 1'b0;
        rsp_ready = 1'b0;
        req_index = '0;
        case_count = 0;
        repeat (4) @(negedge control_clock);
        reset_dc = 1'b0;

        fd = $fopen("supervisor_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open supervisor_cases.txt");
            $display("TESTBENCH FAILED");
            $fatal(1, "case file missing");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.getc(0) != "#") begin
                fields = $sscanf(line, "%s %d %d %d", op, arg_a, arg_b, expected);
                if (fields == 4) begin
                    run_case(op, arg_a, arg_b, expected);
                    case_count++;
                end
            end
        end
        $fclose(fd);

        if (case_count > 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("no cases found in supervisor_cases.txt");
            $display("TESTBENCH FAILED");
            $fatal(1, "empty case file");
        end
    end

endmodule
